//--- dv/sceneRender_testdata.txt
# O  bird0 X Y, bird1 X Y, then X Y of shots 0..7, then shot active flags (hex)
# P  startOfFrame X Y, colour (hex), birdHit and shotHit (hex) seen 3 cycles later
O 100 50 200 50  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  00
P 0 10 10 5C 0 00
P 0 20 10 5C 0 00
P 1 0 0 5C 0 00
P 0 100 50 5C 0 00
P 0 115 65 5C 0 00
P 0 115 50 5C 0 00
P 0 107 57 E0 0 00
P 0 108 58 E0 0 00
P 0 107 50 E0 0 00
P 0 104 54 E0 0 00
P 0 103 53 5C 0 00
P 0 207 57 E0 0 00
P 0 250 50 5C 0 00
O 100 50 200 50  300 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0  00
P 0 300 100 5C 0 00
P 0 301 103 5C 0 00
O 100 50 200 50  300 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0  01
P 0 300 100 FC 0 00
P 0 303 107 FC 0 00
P 0 304 100 5C 0 00
P 0 300 108 5C 0 00
P 0 299 100 5C 0 00
P 1 0 0 5C 0 00
O 100 50 108 50  300 100 0 0 0 0 118 55 0 0 0 0 0 0 0 0  08
P 0 112 57 E0 0 00
P 0 119 57 FC 0 00
P 0 120 60 FC 0 00
P 0 121 63 5C 0 00
P 0 108 50 E0 0 00
P 1 0 0 5C 2 08
O 100 50 108 50  300 100 0 0 0 0 400 200 0 0 0 0 0 0 0 0  08
P 0 400 200 FC 0 00
P 0 119 57 E0 0 00
P 0 50 50 5C 0 00
O 100 50 108 50  300 100 0 0 0 0 118 55 0 0 0 0 0 0 0 0  08
P 1 119 57 FC 0 00
P 0 60 60 5C 0 00
P 0 70 70 5C 0 00
P 1 0 0 5C 2 08
P 0 10 10 5C 0 00
P 0 20 20 5C 0 00
P 1 0 0 5C 0 00
P 0 5 5 5C 0 00

//--- vlog.f
+incdir+verilog
verilog/renderPkg.sv
verilog/birdLayer.sv
verilog/shotLayer.sv
verilog/sceneMixer.sv
verilog/sceneRender.sv
dv/sceneRenderTb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		-f vlog.f --top-module sceneRenderTb

run: build
	./obj_dir/VsceneRenderTb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f vlog.f --top-module sceneRenderTb

clean:
	rm -rf obj_dir sim.log

//--- dv/sceneRenderTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module sceneRenderTb;

	import renderPkg::*;

	logic clk;
	logic reset;
	coord_t pixelX;
	coord_t pixelY;
	logic startOfFrame;
	coord_t [`NUM_BIRDS-1:0] birdX;
	coord_t [`NUM_BIRDS-1:0] birdY;
	coord_t [`NUM_SHOTS-1:0] shotX;
	coord_t [`NUM_SHOTS-1:0] shotY;
	logic [`NUM_SHOTS-1:0] shotActive;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic [`NUM_BIRDS-1:0] birdHit;
	logic [`NUM_SHOTS-1:0] shotHit;

	// One entry per data line, in file order
	bit stepIsObj [$];
	logic pSof [$];
	coord_t pX [$];
	coord_t pY [$];
	color_u pColor [$];
	logic [`NUM_BIRDS-1:0] pBird [$];
	logic [`NUM_SHOTS-1:0] pShot [$];
	coord_t [`NUM_BIRDS-1:0] objBirdX [$];
	coord_t [`NUM_BIRDS-1:0] objBirdY [$];
	coord_t [`NUM_SHOTS-1:0] objShotX [$];
	coord_t [`NUM_SHOTS-1:0] objShotY [$];
	logic [`NUM_SHOTS-1:0] objActive [$];

	// Entry 0 is the pixel driven one cycle ago, entry 2 three cycles ago
	color_u dlColor [3];
	logic [`NUM_BIRDS-1:0] dlBird [3];
	logic [`NUM_SHOTS-1:0] dlShot [3];

	int cycleCount;
	int cycleLimit;
	int pixIdx;
	int objIdx;
	color_u idleColor;

	sceneRender sceneRender_i (
		.clk(clk),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.startOfFrame(startOfFrame),
		.birdX(birdX),
		.birdY(birdY),
		.shotX(shotX),
		.shotY(shotY),
		.shotActive(shotActive),
		.red(red),
		.green(green),
		.blue(blue),
		.birdHit(birdHit),
		.shotHit(shotHit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			abortRun($sformatf("Timeout: the run did not end within %0d cycles", cycleLimit));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expected values and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel bit 7-k takes colour bit (width-1 - k mod width), MSB first
	function automatic logic [7:0] repeatBits(input logic [2:0] bits, input int width);
		logic [7:0] result;
		for (int k = 0; k < 8; k++) begin
			result[7 - k] = bits[width - 1 - (k % width)];
		end
		return result;
	endfunction

	task automatic compareColor(input logic [7:0] gotRed, input logic [7:0] gotGreen,
		input logic [7:0] gotBlue, input color_u expColor);
		logic [7:0] expRed;
		logic [7:0] expGreen;
		logic [7:0] expBlue;
		expRed = repeatBits(expColor.raw[7:5], 3);
		expGreen = repeatBits(expColor.raw[4:2], 3);
		expBlue = repeatBits({1'b0, expColor.raw[1:0]}, 2);
		if (gotRed !== expRed) begin
			abortRun($sformatf("FAILED red: got 0x%02h, expected 0x%02h", gotRed, expRed));
		end
		if (gotGreen !== expGreen) begin
			abortRun($sformatf("FAILED green: got 0x%02h, expected 0x%02h", gotGreen, expGreen));
		end
		if (gotBlue !== expBlue) begin
			abortRun($sformatf("FAILED blue: got 0x%02h, expected 0x%02h", gotBlue, expBlue));
		end
	endtask

	task automatic compareHits(input logic [`NUM_BIRDS-1:0] gotBird,
		input logic [`NUM_BIRDS-1:0] expBird, input logic [`NUM_SHOTS-1:0] gotShot,
		input logic [`NUM_SHOTS-1:0] expShot);
		if (gotBird !== expBird) begin
			abortRun($sformatf("FAILED birdHit: got 0x%h, expected 0x%h", gotBird, expBird));
		end
		if (gotShot !== expShot) begin
			abortRun($sformatf("FAILED shotHit: got 0x%h, expected 0x%h", gotShot, expShot));
		end
	endtask

	// Colour lags the pixel by two cycles, the hit pulse by three
	task automatic checkOutputs();
		compareColor(red, green, blue, dlColor[1]);
		compareHits(birdHit, dlBird[2], shotHit, dlShot[2]);
	endtask

	task automatic shiftExpected(input color_u c, input logic [`NUM_BIRDS-1:0] b,
		input logic [`NUM_SHOTS-1:0] s);
		dlColor[2] = dlColor[1];
		dlBird[2] = dlBird[1];
		dlShot[2] = dlShot[1];
		dlColor[1] = dlColor[0];
		dlBird[1] = dlBird[0];
		dlShot[1] = dlShot[0];
		dlColor[0] = c;
		dlBird[0] = b;
		dlShot[0] = s;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic loadTestData();
		int fd;
		int code;
		int ch;
		int valA;
		int valB;
		int valC;
		int valD;
		int valE;
		int valF;
		logic [7:0] tag;
		color_u rawColor;
		coord_t [`NUM_BIRDS-1:0] bx;
		coord_t [`NUM_BIRDS-1:0] by;
		coord_t [`NUM_SHOTS-1:0] sx;
		coord_t [`NUM_SHOTS-1:0] sy;
		fd = $fopen("dv/sceneRender_testdata.txt", "r");
		if (fd == 0) begin
			abortRun("Cannot open the data file dv/sceneRender_testdata.txt");
		end
		code = $fscanf(fd, " %c", tag);
		while (code == 1) begin
			if (tag == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (tag == "O") begin
				for (int i = 0; i < `NUM_BIRDS; i++) begin
					code = $fscanf(fd, "%d %d", valA, valB);
					if (code != 2) begin
						abortRun("An object line in the data file has a bad bird position");
					end
					bx[i] = coord_t'(valA);
					by[i] = coord_t'(valB);
				end
				for (int j = 0; j < `NUM_SHOTS; j++) begin
					code = $fscanf(fd, "%d %d", valA, valB);
					if (code != 2) begin
						abortRun("An object line in the data file has a bad shot position");
					end
					sx[j] = coord_t'(valA);
					sy[j] = coord_t'(valB);
				end
				code = $fscanf(fd, "%h", valA);
				if (code != 1) begin
					abortRun("An object line in the data file has no active flags");
				end
				stepIsObj.push_back(1'b1);
				objBirdX.push_back(bx);
				objBirdY.push_back(by);
				objShotX.push_back(sx);
				objShotY.push_back(sy);
				objActive.push_back(valA[`NUM_SHOTS-1:0]);
			end else if (tag == "P") begin
				code = $fscanf(fd, "%d %d %d %h %h %h", valA, valB, valC, valD, valE, valF);
				if (code != 6) begin
					abortRun("A pixel line in the data file does not hold six values");
				end
				rawColor.raw = valD[7:0];
				stepIsObj.push_back(1'b0);
				pSof.push_back(valA != 0);
				pX.push_back(coord_t'(valB));
				pY.push_back(coord_t'(valC));
				pColor.push_back(rawColor);
				pBird.push_back(valE[`NUM_BIRDS-1:0]);
				pShot.push_back(valF[`NUM_SHOTS-1:0]);
			end else begin
				abortRun("The data file holds a line with an unknown tag");
			end
			code = $fscanf(fd, " %c", tag);
		end
		$fclose(fd);
	endtask

	task automatic driveIdle();
		startOfFrame = 1'b0;
		pixelX = coord_t'(-500);
		pixelY = coord_t'(-500);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		cycleCount = 0;
		cycleLimit = 1000;
		reset = 1'b1;
		driveIdle();
		birdX = '0;
		birdY = '0;
		shotX = '0;
		shotY = '0;
		shotActive = '0;
		idleColor.raw = `BACKGROUND_COLOR;
		for (int k = 0; k < 3; k++) begin
			dlColor[k] = idleColor;
			dlBird[k] = '0;
			dlShot[k] = '0;
		end
		loadTestData();
		cycleLimit = pSof.size() + 20;

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		pixIdx = 0;
		objIdx = 0;
		for (int s = 0; s < stepIsObj.size(); s++) begin
			if (stepIsObj[s]) begin
				birdX = objBirdX[objIdx];
				birdY = objBirdY[objIdx];
				shotX = objShotX[objIdx];
				shotY = objShotY[objIdx];
				shotActive = objActive[objIdx];
				objIdx++;
			end else begin
				checkOutputs();
				startOfFrame = pSof[pixIdx];
				pixelX = pX[pixIdx];
				pixelY = pY[pixIdx];
				shiftExpected(pColor[pixIdx], pBird[pixIdx], pShot[pixIdx]);
				pixIdx++;
				@(negedge clk);
			end
		end

		// Drain the three pixels still in flight
		repeat (3) begin
			checkOutputs();
			driveIdle();
			shiftExpected(idleColor, '0, '0);
			@(negedge clk);
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/sceneRender.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module sceneRender (
	input logic clk,
	input logic reset,
	input renderPkg::coord_t pixelX,
	input renderPkg::coord_t pixelY,
	input logic startOfFrame,
	input renderPkg::coord_t [`NUM_BIRDS-1:0] birdX,
	input renderPkg::coord_t [`NUM_BIRDS-1:0] birdY,
	input renderPkg::coord_t [`NUM_SHOTS-1:0] shotX,
	input renderPkg::coord_t [`NUM_SHOTS-1:0] shotY,
	input logic [`NUM_SHOTS-1:0] shotActive,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic [`NUM_BIRDS-1:0] birdHit,
	output logic [`NUM_SHOTS-1:0] shotHit
);

	import renderPkg::*;

	logic [`NUM_BIRDS-1:0] birdRequest;
	logic birdAny;
	color_u birdColor;
	logic [`NUM_SHOTS-1:0] shotRequest;
	logic shotAny;
	color_u shotColor;

	birdLayer birdLayer_i (
		.clk(clk),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.birdX(birdX),
		.birdY(birdY),
		.birdRequest(birdRequest),
		.birdAny(birdAny),
		.birdColor(birdColor)
	);

	shotLayer shotLayer_i (
		.clk(clk),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.shotX(shotX),
		.shotY(shotY),
		.shotActive(shotActive),
		.shotRequest(shotRequest),
		.shotAny(shotAny),
		.shotColor(shotColor)
	);

	// The mixer gets the raw strobe and lines it up with the layer data itself
	sceneMixer sceneMixer_i (
		.clk(clk),
		.reset(reset),
		.startOfFrame(startOfFrame),
		.birdRequest(birdRequest),
		.birdAny(birdAny),
		.birdColor(birdColor),
		.shotRequest(shotRequest),
		.shotAny(shotAny),
		.shotColor(shotColor),
		.red(red),
		.green(green),
		.blue(blue),
		.birdHit(birdHit),
		.shotHit(shotHit)
	);

endmodule

`default_nettype wire

//--- verilog/sceneMixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module sceneMixer (
	input logic clk,
	input logic reset,
	input logic startOfFrame,
	input logic [`NUM_BIRDS-1:0] birdRequest,
	input logic birdAny,
	input renderPkg::color_u birdColor,
	input logic [`NUM_SHOTS-1:0] shotRequest,
	input logic shotAny,
	input renderPkg::color_u shotColor,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic [`NUM_BIRDS-1:0] birdHit,
	output logic [`NUM_SHOTS-1:0] shotHit
);

	import renderPkg::*;

	color_u mixColor;
	color_u bgColor;
	logic sofD1;
	logic sofD2;
	logic [`NUM_BIRDS-1:0] birdColl;
	logic [`NUM_SHOTS-1:0] shotColl;
	logic [`NUM_BIRDS-1:0] birdFlags;
	logic [`NUM_SHOTS-1:0] shotFlags;

	function automatic logic [7:0] expand3(input logic [2:0] v);
		return {v, v, v[2:1]};
	endfunction

	function automatic logic [7:0] expand2(input logic [1:0] v);
		return {4{v}};
	endfunction

	assign bgColor.raw = `BACKGROUND_COLOR;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Colour path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shots are drawn over birds, birds over the background
	always_comb begin
		if (shotAny) begin
			mixColor = shotColor;
		end else if (birdAny) begin
			mixColor = birdColor;
		end else begin
			mixColor = bgColor;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			red <= expand3(bgColor.field.red);
			green <= expand3(bgColor.field.green);
			blue <= expand2(bgColor.field.blue);
		end else begin
			red <= expand3(mixColor.field.red);
			green <= expand3(mixColor.field.green);
			blue <= expand2(mixColor.field.blue);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Collision accumulation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// The collision stage sits level with the colour register, so sofD2 marks
	// the strobe pixel in birdColl and shotColl
	always_ff @(posedge clk) begin
		if (reset) begin
			sofD1 <= 1'b0;
			sofD2 <= 1'b0;
			birdColl <= '0;
			shotColl <= '0;
			birdFlags <= '0;
			shotFlags <= '0;
			birdHit <= '0;
			shotHit <= '0;
		end else begin
			sofD1 <= startOfFrame;
			sofD2 <= sofD1;
			birdColl <= birdRequest & {`NUM_BIRDS{shotAny}};
			shotColl <= shotRequest & {`NUM_SHOTS{birdAny}};
			if (sofD2) begin
				// Report the finished frame, the strobe pixel starts the new one
				birdHit <= birdFlags;
				shotHit <= shotFlags;
				birdFlags <= birdColl;
				shotFlags <= shotColl;
			end else begin
				birdHit <= '0;
				shotHit <= '0;
				birdFlags <= birdFlags | birdColl;
				shotFlags <= shotFlags | shotColl;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/shotLayer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module shotLayer (
	input logic clk,
	input logic reset,
	input renderPkg::coord_t pixelX,
	input renderPkg::coord_t pixelY,
	input renderPkg::coord_t [`NUM_SHOTS-1:0] shotX,
	input renderPkg::coord_t [`NUM_SHOTS-1:0] shotY,
	input logic [`NUM_SHOTS-1:0] shotActive,
	output logic [`NUM_SHOTS-1:0] shotRequest,
	output logic shotAny,
	output renderPkg::color_u shotColor
);

	import renderPkg::*;

	logic [`NUM_SHOTS-1:0] hitNow;
	color_u pickColor;

	for (genvar j = 0; j < `NUM_SHOTS; j++) begin : gShot
		logic signed [11:0] dx;
		logic signed [11:0] dy;

		assign dx = {pixelX[10], pixelX} - {shotX[j][10], shotX[j]};
		assign dy = {pixelY[10], pixelY} - {shotY[j][10], shotY[j]};

		// A parked shot keeps its last position, so the flag must gate it
		assign hitNow[j] = shotActive[j]
			&& (dx >= 0) && (dx < 12'(`SHOT_W))
			&& (dy >= 0) && (dy < 12'(`SHOT_H));
	end

	assign pickColor.raw = (|hitNow) ? `SHOT_COLOR : 8'h00;

	always_ff @(posedge clk) begin
		if (reset) begin
			shotRequest <= '0;
			shotAny <= 1'b0;
		end else begin
			shotRequest <= hitNow;
			shotAny <= |hitNow;
		end
	end

	always_ff @(posedge clk) begin
		shotColor <= pickColor;
	end

endmodule

`default_nettype wire

//--- verilog/birdLayer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module birdLayer (
	input logic clk,
	input logic reset,
	input renderPkg::coord_t pixelX,
	input renderPkg::coord_t pixelY,
	input renderPkg::coord_t [`NUM_BIRDS-1:0] birdX,
	input renderPkg::coord_t [`NUM_BIRDS-1:0] birdY,
	output logic [`NUM_BIRDS-1:0] birdRequest,
	output logic birdAny,
	output renderPkg::color_u birdColor
);

	import renderPkg::*;

	logic [`NUM_BIRDS-1:0] hitNow;
	color_u pickColor;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-bird sprite test
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar i = 0; i < `NUM_BIRDS; i++) begin : gBird
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		logic signed [11:0] foldX;
		logic signed [11:0] foldY;
		logic signed [11:0] distSum;
		logic inBox;

		// One extra bit so the offset cannot wrap at the screen edges
		assign dx = {pixelX[10], pixelX} - {birdX[i][10], birdX[i]};
		assign dy = {pixelY[10], pixelY} - {birdY[i][10], birdY[i]};
		assign inBox = (dx >= 0) && (dx < 12'(`BIRD_SIZE))
			&& (dy >= 0) && (dy < 12'(`BIRD_SIZE));

		// Doubled offsets put the box centre on an integer point
		assign foldX = (dx <<< 1) - 12'(`BIRD_SIZE - 1);
		assign foldY = (dy <<< 1) - 12'(`BIRD_SIZE - 1);
		assign distSum = (foldX[11] ? -foldX : foldX) + (foldY[11] ? -foldY : foldY);

		assign hitNow[i] = inBox && (distSum <= 12'(`BIRD_SIZE));
	end

	// Every bird shares one colour, so any covering bird gives it
	assign pickColor.raw = (|hitNow) ? `BIRD_COLOR : 8'h00;

	always_ff @(posedge clk) begin
		if (reset) begin
			birdRequest <= '0;
			birdAny <= 1'b0;
		end else begin
			birdRequest <= hitNow;
			birdAny <= |hitNow;
		end
	end

	always_ff @(posedge clk) begin
		birdColor <= pickColor;
	end

endmodule

`default_nettype wire

//--- verilog/renderPkg.sv
`default_nettype none

package renderPkg;

	// Screen coordinate, may go negative when an object enters from the left or top
	typedef logic signed [10:0] coord_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Colour word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// The layers only pass the byte along, the mixer splits it into channels
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} colorFields_t;

	typedef union packed {
		logic [7:0] raw;
		colorFields_t field;
	} color_u;

endpackage

`default_nettype wire

//--- verilog/render_cfg.svh
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_BIRDS 2
`define NUM_SHOTS 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite sizes in pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Birds live in a square box, the diamond is cut out of it
`define BIRD_SIZE 16
`define SHOT_W 4
`define SHOT_H 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colours in RRRGGGBB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BIRD_COLOR 8'hE0
`define SHOT_COLOR 8'hFC
`define BACKGROUND_COLOR 8'h5C

`endif
